//--- design/mips_pkg.sv
//////////////////////////////
// shared widths, encodings and pipeline payload structs for the
// five-stage MIPS core, imported by every stage
//////////////////////////////

package mips_pkg;

   localparam int WORD_W    = 32;
   localparam int REG_IDX_W = 5;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   localparam word_t    RESET_PC = 32'h0000_0000;
   localparam reg_idx_t ZERO_REG = 5'd0;

   // primary opcodes, instr[31:26]
   typedef enum logic [5:0] {
      RTYPE = 6'h00,
      J     = 6'h02,
      BEQ   = 6'h04,
      BNE   = 6'h05,
      ADDIU = 6'h09,
      SLTI  = 6'h0a,
      ORI   = 6'h0d,
      LUI   = 6'h0f,
      LW    = 6'h23,
      SW    = 6'h2b,
      HALT  = 6'h3f
   } opcode_e;

   // r-type function codes, instr[5:0]
   typedef enum logic [5:0] {
      ADDU = 6'h21,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      SLT  = 6'h2a
   } funct_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0, // must stay zero, bubbles decode to add
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_e;

   //////////////////////////////
   // pipeline payloads
   //////////////////////////////

   typedef struct packed {
      alu_op_e alu_op;
      logic    alu_src_imm;
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    branch_eq;
      logic    branch_ne;
      logic    jump;
      logic    lui;
      logic    halt;
   } ctrl_t;

   typedef struct packed {
      word_t instr;
      word_t npc;    // pc + 4
   } fetch_t;

   typedef struct packed {
      ctrl_t    ctrl;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t dst;
      word_t    rdat1;
      word_t    rdat2;
      word_t    imm;
      word_t    npc;
      word_t    jaddr;
   } idex_t;

   typedef struct packed {
      ctrl_t    ctrl;
      reg_idx_t dst;
      word_t    alu_out;
      word_t    sdata;   // store data after forwarding
   } exmem_t;

   typedef struct packed {
      logic     reg_write;
      logic     mem_read;
      logic     halt;
      reg_idx_t dst;
      word_t    alu_out;
      word_t    ldata;
   } memwb_t;

   typedef struct packed {
      logic     wen;
      reg_idx_t waddr;
      word_t    wdata;
   } wb_t;

   typedef struct packed {
      logic  taken;
      word_t target;
   } redirect_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t wdata;
   } dmem_req_t;

endpackage

//--- design/pipe_reg.sv
//////////////////////////////
// generic pipeline register, payload set by type parameter
// flush loads an all-zero bubble
//////////////////////////////
`timescale 1ns/10ps

module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     CLK,
   input  logic     nRST,
   input  logic     en_i,
   input  logic     flush_i,   // wins over en_i
   input  payload_t d_i,
   output payload_t q_o
);

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         q_o <= '0;
      end
      else if (flush_i) begin
         q_o <= '0;            // bubble, all controls inactive
      end
      else if (en_i) begin
         q_o <= d_i;
      end
   end

endmodule

//--- design/fetch_stage.sv
//////////////////////////////
// instruction fetch: program counter, next pc select
// and the IF/ID register
//////////////////////////////
`timescale 1ns/10ps

module fetch_stage
   import mips_pkg::*;
(
   input  logic      CLK,
   input  logic      nRST,
   input  word_t     imem_data_i,
   output word_t     imem_addr_o,
   input  logic      stall_i,
   input  redirect_t redirect_i,
   input  logic      halt_i,
   output fetch_t    if_id_o
);

   word_t  pc;
   word_t  pc_plus4;
   word_t  next_pc;
   fetch_t if_id_d;

   assign pc_plus4    = pc + 32'd4;
   assign imem_addr_o = pc;

   // halt freezes, then redirect, then load-use hold
   always_comb begin
      if (halt_i) begin
         next_pc = pc;
      end
      else if (redirect_i.taken) begin
         next_pc = redirect_i.target;
      end
      else if (stall_i) begin
         next_pc = pc;
      end
      else begin
         next_pc = pc_plus4;
      end
   end

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         pc <= RESET_PC;
      end
      else begin
         pc <= next_pc;
      end
   end

   assign if_id_d.instr = imem_data_i;
   assign if_id_d.npc   = pc_plus4;

   // squashed on redirect, drained to bubbles once halted
   pipe_reg #(.payload_t(fetch_t)) i_if_id_reg (
      .CLK     (CLK),
      .nRST    (nRST),
      .en_i    (!stall_i && !halt_i),
      .flush_i (redirect_i.taken || halt_i),
      .d_i     (if_id_d),
      .q_o     (if_id_o)
   );

endmodule

//--- design/register_file.sv
//////////////////////////////
// 32 x 32 register file, r0 reads zero
// same-cycle write is bypassed to the read ports
//////////////////////////////
`timescale 1ns/10ps

module register_file
   import mips_pkg::*;
(
   input  logic     CLK,
   input  logic     nRST,
   input  reg_idx_t rsel1_i,
   input  reg_idx_t rsel2_i,
   input  wb_t      wb_i,
   output word_t    rdat1_o,
   output word_t    rdat2_o
);

   word_t regs [2**REG_IDX_W];
   logic  wr_ok;

   assign wr_ok = wb_i.wen && (wb_i.waddr != ZERO_REG);

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < 2**REG_IDX_W; i++) begin
            regs[i] <= '0;
         end
      end
      else if (wr_ok) begin
         regs[wb_i.waddr] <= wb_i.wdata;
      end
   end

   // write-before-read
   assign rdat1_o = (wr_ok && wb_i.waddr == rsel1_i) ? wb_i.wdata : regs[rsel1_i];
   assign rdat2_o = (wr_ok && wb_i.waddr == rsel2_i) ? wb_i.wdata : regs[rsel2_i];

endmodule

//--- design/decode_stage.sv
//////////////////////////////
// instruction decode: control decode, immediate extension,
// register read, load-use detect and the ID/EX register
//////////////////////////////
`timescale 1ns/10ps

module decode_stage
   import mips_pkg::*;
(
   input  logic      CLK,
   input  logic      nRST,
   input  fetch_t    if_id_i,
   input  wb_t       wb_i,
   input  redirect_t redirect_i,
   output logic      stall_o,
   output idex_t     id_ex_o
);

   opcode_e  op;
   funct_e   fn;
   reg_idx_t rs, rt, rd;
   ctrl_t    ctrl;
   word_t    rdat1, rdat2;
   idex_t    id_ex_d;

   assign op = opcode_e'(if_id_i.instr[31:26]);
   assign fn = funct_e'(if_id_i.instr[5:0]);
   assign rs = if_id_i.instr[25:21];
   assign rt = if_id_i.instr[20:16];
   assign rd = if_id_i.instr[15:11];

   register_file i_regfile (
      .CLK     (CLK),
      .nRST    (nRST),
      .rsel1_i (rs),
      .rsel2_i (rt),
      .wb_i    (wb_i),
      .rdat1_o (rdat1),
      .rdat2_o (rdat2)
   );

   //////////////////////////////
   // control decode
   //////////////////////////////
   always_comb begin
      ctrl = '0;   // unknown encodings behave as nop
      case (op)
         RTYPE: begin
            ctrl.reg_write = 1'b1;
            case (fn)
               ADDU:    ctrl.alu_op = ALU_ADD;
               SUBU:    ctrl.alu_op = ALU_SUB;
               AND:     ctrl.alu_op = ALU_AND;
               OR:      ctrl.alu_op = ALU_OR;
               SLT:     ctrl.alu_op = ALU_SLT;
               default: ctrl.reg_write = 1'b0;
            endcase
         end
         ADDIU: {ctrl.alu_src_imm, ctrl.reg_write} = 2'b11;
         SLTI: begin
            ctrl.alu_op = ALU_SLT;
            {ctrl.alu_src_imm, ctrl.reg_write} = 2'b11;
         end
         ORI: begin
            ctrl.alu_op = ALU_OR;
            {ctrl.alu_src_imm, ctrl.reg_write} = 2'b11;
         end
         LUI:     {ctrl.lui, ctrl.alu_src_imm, ctrl.reg_write} = 3'b111;
         LW:      {ctrl.alu_src_imm, ctrl.reg_write, ctrl.mem_read} = 3'b111;
         SW:      {ctrl.alu_src_imm, ctrl.mem_write} = 2'b11;
         BEQ:     ctrl.branch_eq = 1'b1;
         BNE:     ctrl.branch_ne = 1'b1;
         J:       ctrl.jump = 1'b1;
         HALT:    ctrl.halt = 1'b1;
         default: ctrl = '0;
      endcase
   end

   // load in EX feeding this instruction, hold one cycle
   assign stall_o = id_ex_o.ctrl.mem_read && (id_ex_o.dst != ZERO_REG) &&
                    (id_ex_o.dst == rs || id_ex_o.dst == rt);

   assign id_ex_d.ctrl  = ctrl;
   assign id_ex_d.rs    = rs;
   assign id_ex_d.rt    = rt;
   assign id_ex_d.dst   = (op == RTYPE) ? rd : rt;
   assign id_ex_d.rdat1 = rdat1;
   assign id_ex_d.rdat2 = rdat2;
   assign id_ex_d.imm   = (op == ORI) ? {16'h0000, if_id_i.instr[15:0]}
                                      : {{16{if_id_i.instr[15]}}, if_id_i.instr[15:0]};
   assign id_ex_d.npc   = if_id_i.npc;
   assign id_ex_d.jaddr = {if_id_i.npc[31:28], if_id_i.instr[25:0], 2'b00};

   pipe_reg #(.payload_t(idex_t)) i_id_ex_reg (
      .CLK     (CLK),
      .nRST    (nRST),
      .en_i    (1'b1),
      .flush_i (stall_o || redirect_i.taken),   // bubble on stall or squash
      .d_i     (id_ex_d),
      .q_o     (id_ex_o)
   );

endmodule

//--- design/execute_stage.sv
//////////////////////////////
// execute: operand forwarding, ALU, branch/jump resolution
// and the EX/MEM register
//////////////////////////////
`timescale 1ns/10ps

module execute_stage
   import mips_pkg::*;
(
   input  logic      CLK,
   input  logic      nRST,
   input  idex_t     id_ex_i,
   input  wb_t       wb_i,
   output redirect_t redirect_o,
   output exmem_t    ex_mem_o
);

   word_t  fwd_a, fwd_b;
   word_t  alu_a, alu_b;
   word_t  alu_out;
   word_t  br_target;
   logic   equal;
   exmem_t ex_mem_d;

   // mem stage beats wb stage, r0 never forwarded
   function automatic word_t fwd_sel(reg_idx_t src, word_t rdat, exmem_t em, wb_t wb);
      word_t val;
      val = rdat;
      if (wb.wen && wb.waddr != ZERO_REG && wb.waddr == src) begin
         val = wb.wdata;
      end
      // loads never forward from mem, the load-use stall covers them
      if (em.ctrl.reg_write && !em.ctrl.mem_read && em.dst != ZERO_REG && em.dst == src) begin
         val = em.alu_out;
      end
      return val;
   endfunction

   assign fwd_a = fwd_sel(id_ex_i.rs, id_ex_i.rdat1, ex_mem_o, wb_i);
   assign fwd_b = fwd_sel(id_ex_i.rt, id_ex_i.rdat2, ex_mem_o, wb_i);

   //////////////////////////////
   // alu
   //////////////////////////////
   assign alu_a = id_ex_i.ctrl.lui ? '0 : fwd_a;   // lui is 0 + imm<<16

   always_comb begin
      if (id_ex_i.ctrl.lui) begin
         alu_b = {id_ex_i.imm[15:0], 16'h0000};
      end
      else if (id_ex_i.ctrl.alu_src_imm) begin
         alu_b = id_ex_i.imm;
      end
      else begin
         alu_b = fwd_b;
      end
   end

   always_comb begin
      case (id_ex_i.ctrl.alu_op)
         ALU_ADD: alu_out = alu_a + alu_b;
         ALU_SUB: alu_out = alu_a - alu_b;
         ALU_AND: alu_out = alu_a & alu_b;
         ALU_OR:  alu_out = alu_a | alu_b;
         ALU_SLT: alu_out = {{(WORD_W-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
         default: alu_out = '0;
      endcase
   end

   //////////////////////////////
   // branch / jump
   //////////////////////////////
   assign equal     = (fwd_a == fwd_b);
   assign br_target = id_ex_i.npc + {id_ex_i.imm[WORD_W-3:0], 2'b00};

   assign redirect_o.taken  = (id_ex_i.ctrl.branch_eq && equal) ||
                              (id_ex_i.ctrl.branch_ne && !equal) ||
                              id_ex_i.ctrl.jump;
   assign redirect_o.target = id_ex_i.ctrl.jump ? id_ex_i.jaddr : br_target;

   assign ex_mem_d.ctrl    = id_ex_i.ctrl;
   assign ex_mem_d.dst     = id_ex_i.dst;
   assign ex_mem_d.alu_out = alu_out;
   assign ex_mem_d.sdata   = fwd_b;         // store data after forwarding

   // never stalled or flushed, branch itself moves on
   pipe_reg #(.payload_t(exmem_t)) i_ex_mem_reg (
      .CLK     (CLK),
      .nRST    (nRST),
      .en_i    (1'b1),
      .flush_i (1'b0),
      .d_i     (ex_mem_d),
      .q_o     (ex_mem_o)
   );

endmodule

//--- design/mem_wb_stage.sv
//////////////////////////////
// memory access, MEM/WB register, writeback select
// and the sticky halt flag
//////////////////////////////
`timescale 1ns/10ps

module mem_wb_stage
   import mips_pkg::*;
(
   input  logic      CLK,
   input  logic      nRST,
   input  exmem_t    ex_mem_i,
   input  word_t     dmem_rdata_i,
   output dmem_req_t dmem_req_o,
   output wb_t       wb_o,
   output logic      halt_o
);

   memwb_t mem_wb_d, mem_wb_q;
   logic   quiet;

   // halt ahead in wb, nothing younger may touch memory
   assign quiet = mem_wb_q.halt || halt_o;

   assign dmem_req_o.ren   = ex_mem_i.ctrl.mem_read && !quiet;
   assign dmem_req_o.wen   = ex_mem_i.ctrl.mem_write && !quiet;
   assign dmem_req_o.addr  = ex_mem_i.alu_out;
   assign dmem_req_o.wdata = ex_mem_i.sdata;

   assign mem_wb_d.reg_write = ex_mem_i.ctrl.reg_write;
   assign mem_wb_d.mem_read  = ex_mem_i.ctrl.mem_read;
   assign mem_wb_d.halt      = ex_mem_i.ctrl.halt;
   assign mem_wb_d.dst       = ex_mem_i.dst;
   assign mem_wb_d.alu_out   = ex_mem_i.alu_out;
   assign mem_wb_d.ldata     = dmem_rdata_i;   // same-cycle load data

   pipe_reg #(.payload_t(memwb_t)) i_mem_wb_reg (
      .CLK     (CLK),
      .nRST    (nRST),
      .en_i    (1'b1),
      .flush_i (1'b0),
      .d_i     (mem_wb_d),
      .q_o     (mem_wb_q)
   );

   assign wb_o.wen   = mem_wb_q.reg_write;
   assign wb_o.waddr = mem_wb_q.dst;
   assign wb_o.wdata = mem_wb_q.mem_read ? mem_wb_q.ldata : mem_wb_q.alu_out;

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         halt_o <= 1'b0;
      end
      else if (mem_wb_q.halt) begin
         halt_o <= 1'b1;   // sticky until reset
      end
   end

endmodule

//--- design/mips_core.sv
//////////////////////////////
// five-stage pipelined MIPS core top level
// same-cycle instruction and data memory ports
//////////////////////////////
`timescale 1ns/10ps

module mips_core
   import mips_pkg::*;
(
   input  logic      CLK,
   input  logic      nRST,
   input  word_t     imem_data_i,
   output word_t     imem_addr_o,
   input  word_t     dmem_rdata_i,
   output dmem_req_t dmem_req_o,
   output logic      halt_o
);

   fetch_t    if_id;
   idex_t     id_ex;
   exmem_t    ex_mem;
   wb_t       wb;
   redirect_t redirect;
   logic      stall;

   fetch_stage i_fetch (
      .CLK         (CLK),
      .nRST        (nRST),
      .imem_data_i (imem_data_i),
      .imem_addr_o (imem_addr_o),
      .stall_i     (stall),
      .redirect_i  (redirect),
      .halt_i      (halt_o),
      .if_id_o     (if_id)
   );

   decode_stage i_decode (
      .CLK        (CLK),
      .nRST       (nRST),
      .if_id_i    (if_id),
      .wb_i       (wb),
      .redirect_i (redirect),
      .stall_o    (stall),
      .id_ex_o    (id_ex)
   );

   execute_stage i_execute (
      .CLK        (CLK),
      .nRST       (nRST),
      .id_ex_i    (id_ex),
      .wb_i       (wb),
      .redirect_o (redirect),
      .ex_mem_o   (ex_mem)
   );

   mem_wb_stage i_mem_wb (
      .CLK          (CLK),
      .nRST         (nRST),
      .ex_mem_i     (ex_mem),
      .dmem_rdata_i (dmem_rdata_i),
      .dmem_req_o   (dmem_req_o),
      .wb_o         (wb),
      .halt_o       (halt_o)
   );

endmodule

//--- test/mips_core_chk.sv
//////////////////////////////
// assertions on the core's top-level ports, bound into mips_core
//////////////////////////////
`timescale 1ns/10ps

module mips_core_chk
   import mips_pkg::*;
(
   input logic      CLK,
   input logic      nRST,
   input word_t     imem_addr_i,
   input dmem_req_t dmem_req_i,
   input logic      halt_i
);

   int fail_cnt = 0;   // read by the testbench at the end of the run

   a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
      !(dmem_req_i.ren && dmem_req_i.wen))
   else begin
      fail_cnt++;
      $error("dmem ren and wen high together");
   end

   // sticky until the next reset
   a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      !$fell(halt_i))
   else begin
      fail_cnt++;
      $error("halt_o fell without reset");
   end

   a_pc_aligned: assert property (@(posedge CLK) disable iff (!nRST)
      imem_addr_i[1:0] == 2'b00)
   else begin
      fail_cnt++;
      $error("imem_addr_o not word aligned");
   end

   a_quiet_halt: assert property (@(posedge CLK) disable iff (!nRST)
      halt_i |-> !(dmem_req_i.ren || dmem_req_i.wen))
   else begin
      fail_cnt++;
      $error("dmem strobe while halted");
   end

endmodule

bind mips_core mips_core_chk i_chk (
   .CLK         (CLK),
   .nRST        (nRST),
   .imem_addr_i (imem_addr_o),
   .dmem_req_i  (dmem_req_o),
   .halt_i      (halt_o)
);

//--- test/mips_core_tb.sv
//////////////////////////////
// testbench for the pipelined MIPS core
// random programs run against a sequential reference model
// with every store and load compared in order
//////////////////////////////
`timescale 1ns/10ps

module mips_core_tb
   import mips_pkg::*;
;

   localparam int N_PROGS      = 20;
   localparam int BODY_LEN     = 48;
   localparam int STORE_BASE   = 248;   // epilogue word slots 249..255
   localparam int MEM_WORDS    = 256;
   localparam int RESET_CYCLES = 4;
   localparam int TAIL_CYCLES  = 8;
   localparam int MAX_CYCLES   = N_PROGS * (60 * 3 + 20);

   logic      CLK;
   logic      nRST;
   word_t     imem_data_i  = '0;
   word_t     dmem_rdata_i = '0;
   word_t     imem_addr_o;
   dmem_req_t dmem_req_o;
   logic      halt_o;

   word_t     imem    [MEM_WORDS];
   word_t     dmem    [MEM_WORDS];
   word_t     mdl_mem [MEM_WORDS];   // reference model data memory
   dmem_req_t exp_stores [$];
   word_t     exp_loads  [$];
   int        cycles = 0;

   mips_core i_mips_core (
      .CLK          (CLK),
      .nRST         (nRST),
      .imem_data_i  (imem_data_i),
      .imem_addr_o  (imem_addr_o),
      .dmem_rdata_i (dmem_rdata_i),
      .dmem_req_o   (dmem_req_o),
      .halt_o       (halt_o)
   );

   initial begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "run stopped at cycle %0d", cycles);
   endtask

   //////////////////////////////
   // compare tasks
   //////////////////////////////
   task automatic check_store(dmem_req_t got, dmem_req_t exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch dmem_req_o: got %h expected %h", got, exp));
      end
   endtask

   task automatic check_load_addr(word_t got, word_t exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch dmem_req_o.addr: got %h expected %h", got, exp));
      end
   endtask

   task automatic check_pc(word_t got, word_t exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch imem_addr_o: got %h expected %h", got, exp));
      end
   endtask

   task automatic check_halt(logic got, logic exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch halt_o: got %h expected %h", got, exp));
      end
   endtask

   //////////////////////////////
   // program generator
   //////////////////////////////
   function automatic word_t r_instr(funct_e fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
      return {RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic word_t i_instr(opcode_e op, reg_idx_t rs, reg_idx_t rt,
                                     logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic funct_e pick_funct();
      case ($urandom_range(4))
         0:       return ADDU;
         1:       return SUBU;
         2:       return AND;
         3:       return OR;
         default: return SLT;
      endcase
   endfunction

   // every byte lane depends on the full word index
   function automatic word_t fill_word(logic [7:0] a, logic [7:0] p);
      return {a, ~a, a ^ p, 8'h5a + a};
   endfunction

   task automatic build_program(logic [7:0] prog);
      int          n;
      int          lim;
      int          hop;
      reg_idx_t    rd, rs, rt;
      logic [15:0] imm;
      logic [15:0] off;
      for (int a = 0; a < MEM_WORDS; a++) begin
         imem[8'(a)]    = '0;   // funct 0 decodes as nop
         dmem[8'(a)]    = fill_word(8'(a), prog);
         mdl_mem[8'(a)] = dmem[8'(a)];
      end
      n = 0;
      while (n < BODY_LEN) begin
         rs  = reg_idx_t'($urandom_range(7));
         rt  = reg_idx_t'($urandom_range(7));
         rd  = reg_idx_t'($urandom_range(7));
         imm = 16'($urandom);
         off = {6'd0, 8'($urandom_range(255)), 2'b00};
         lim = (BODY_LEN - 1 - n < 6) ? BODY_LEN - 1 - n : 6;
         hop = int'($urandom_range(lim));   // forward only and lands at most on the epilogue
         case ($urandom_range(10))
            0, 1, 2: imem[8'(n)] = r_instr(pick_funct(), rd, rs, rt);
            3:       imem[8'(n)] = i_instr(ADDIU, rs, rt, imm);
            4:       imem[8'(n)] = i_instr(ORI, rs, rt, imm);
            5:       imem[8'(n)] = i_instr(LUI, ZERO_REG, rt, imm);
            6: begin
               imem[8'(n)] = i_instr(LW, ZERO_REG, rt, off);
               if (n + 1 < BODY_LEN) begin
                  n++;
                  imem[8'(n)] = r_instr(ADDU, rd, rt, rs);   // load-use right away
               end
            end
            7:       imem[8'(n)] = i_instr(SW, ZERO_REG, rt, off);
            8: begin
               if ($urandom_range(1) == 0) begin
                  imem[8'(n)] = i_instr(BEQ, rs, rt, 16'(hop));
               end
               else begin
                  imem[8'(n)] = i_instr(BNE, rs, rt, 16'(hop));
               end
            end
            9:       imem[8'(n)] = i_instr(SLTI, rs, rt, imm);
            default: imem[8'(n)] = {J, 26'(n + 1 + hop)};
         endcase
         n++;
      end
      for (int r = 1; r < 8; r++) begin
         imem[8'(BODY_LEN + r - 1)] = i_instr(SW, ZERO_REG, reg_idx_t'(r),
                                              16'((STORE_BASE + r) * 4));
      end
      imem[8'(BODY_LEN + 7)] = {HALT, 26'd0};
      // memory traffic past HALT that the core has to hold back
      for (int a = BODY_LEN + 8; a < MEM_WORDS; a++) begin
         if (a % 2 == 0) begin
            imem[8'(a)] = i_instr(SW, ZERO_REG, reg_idx_t'(a % 8), 16'(a * 4));
         end
         else begin
            imem[8'(a)] = i_instr(LW, ZERO_REG, reg_idx_t'(a % 8), 16'(a * 4));
         end
      end
   endtask

   //////////////////////////////
   // sequential reference model
   //////////////////////////////
   task automatic run_model();
      word_t      rf [32];
      word_t      ins, a, b, imm_s, addr;
      logic [7:0] pc;
      dmem_req_t  req;
      rf = '{default: '0};
      pc = 8'd0;
      exp_stores.delete();
      exp_loads.delete();
      while (imem[pc][31:26] != HALT) begin
         ins   = imem[pc];
         a     = rf[ins[25:21]];
         b     = rf[ins[20:16]];
         imm_s = {{16{ins[15]}}, ins[15:0]};
         addr  = a + imm_s;
         pc    = pc + 8'd1;
         case (opcode_e'(ins[31:26]))
            RTYPE: begin
               case (funct_e'(ins[5:0]))
                  ADDU:    rf[ins[15:11]] = a + b;
                  SUBU:    rf[ins[15:11]] = a - b;
                  AND:     rf[ins[15:11]] = a & b;
                  OR:      rf[ins[15:11]] = a | b;
                  SLT:     rf[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: ;
               endcase
            end
            ADDIU: rf[ins[20:16]] = a + imm_s;
            SLTI:  rf[ins[20:16]] = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
            ORI:   rf[ins[20:16]] = a | {16'h0000, ins[15:0]};
            LUI:   rf[ins[20:16]] = {ins[15:0], 16'h0000};
            LW: begin
               exp_loads.push_back(addr);
               rf[ins[20:16]] = mdl_mem[addr[9:2]];
            end
            SW: begin
               req       = '0;
               req.wen   = 1'b1;
               req.addr  = addr;
               req.wdata = b;
               exp_stores.push_back(req);
               mdl_mem[addr[9:2]] = b;
            end
            BEQ:     pc = (a == b) ? pc + imm_s[7:0] : pc;
            BNE:     pc = (a != b) ? pc + imm_s[7:0] : pc;
            J:       pc = ins[7:0];   // word index since the program sits at 0
            default: ;
         endcase
         rf[0] = '0;
      end
   endtask

   // memories answer in the same cycle on the falling edge
   always @(negedge CLK) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         abort_run($sformatf("timeout, core did not halt within %0d cycles", MAX_CYCLES));
      end
      if (dmem_req_o.wen) begin
         if (exp_stores.size() == 0) begin
            abort_run("store strobe seen when no store was expected");
         end
         else begin
            check_store(dmem_req_o, exp_stores.pop_front());
            dmem[dmem_req_o.addr[9:2]] = dmem_req_o.wdata;
         end
      end
      if (dmem_req_o.ren) begin
         if (exp_loads.size() == 0) begin
            abort_run("load strobe seen when no load was expected");
         end
         else begin
            check_load_addr(dmem_req_o.addr, exp_loads.pop_front());
         end
      end
      imem_data_i  = imem[imem_addr_o[9:2]];
      dmem_rdata_i = dmem[dmem_req_o.addr[9:2]];
   end

   initial begin
      void'($urandom(32'hc4f879f6));
      nRST = 1'b0;
      for (int p = 0; p < N_PROGS; p++) begin
         @(negedge CLK);
         nRST = 1'b0;
         build_program(8'(p));
         run_model();
         repeat (RESET_CYCLES) @(negedge CLK);
         check_pc(imem_addr_o, RESET_PC);
         check_halt(halt_o, 1'b0);
         nRST = 1'b1;
         while (!halt_o) @(negedge CLK);
         if (exp_stores.size() != 0 || exp_loads.size() != 0) begin
            abort_run($sformatf("halt_o rose with %0d stores and %0d loads outstanding",
                                exp_stores.size(), exp_loads.size()));
         end
         repeat (TAIL_CYCLES) begin
            @(negedge CLK);
            check_halt(halt_o, 1'b1);
         end
      end
      if (i_mips_core.i_chk.fail_cnt == 0) begin
         $display("Test OK");
         $finish;
      end
      else begin
         $display("%0d bound assertion failures", i_mips_core.i_chk.fail_cnt);
         $display("Test FAILED");
         $fatal(1, "bound assertions failed");
      end
   end

endmodule

//--- mips_core.f
design/mips_pkg.sv
design/pipe_reg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/mips_core.sv
test/mips_core_chk.sv
test/mips_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = mips_core_tb
FILELIST  = mips_core.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
